// ==== spi_pkg.sv ====
`default_nettype none

package spi_pkg;

  // One byte on the SPI wire
  typedef logic [7:0] spi_byte_t;

  // Per-channel configuration
  // [3:2] speed select, [1] CPOL, [0] CPHA
  typedef logic [3:0] spi_conf_t;

  // Transceiver FSM
  typedef enum logic [1:0] {
    XCVR_IDLE,
    XCVR_START,  // SCLK still idle, first bit on MOSI
    XCVR_LEAD,
    XCVR_TRAIL
  } xcvr_state_t;

  // SCLK half-period rates per speed select
  localparam int unsigned SPEED0_HZ = 1_000_000;
  localparam int unsigned SPEED1_HZ = 10_000_000;
  localparam int unsigned SPEED2_HZ = 20_000_000;
  localparam int unsigned SPEED3_HZ = 30_000_000;

  // Field positions inside spi_conf_t
  localparam int unsigned CONF_CPHA_BIT = 0;
  localparam int unsigned CONF_CPOL_BIT = 1;
  localparam int unsigned CONF_SPEED_LSB = 2;

  // Bits per transfer
  localparam int unsigned XFER_BITS = 8;

endpackage

`default_nettype wire

// ==== spi_xcvr.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_xcvr #(
  parameter int unsigned CLK_FREQ_HZ = 100_000_000
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  spi_pkg::spi_conf_t conf,
  input  logic              start,
  input  spi_pkg::spi_byte_t tx,
  output spi_pkg::spi_byte_t rx,
  output logic              done,
  input  logic              miso,
  output logic              mosi,
  output logic              sclk
);

  import spi_pkg::*;

  // Divider per speed select, never below one clock
  localparam int unsigned DIV0 = (CLK_FREQ_HZ / SPEED0_HZ > 0) ? CLK_FREQ_HZ / SPEED0_HZ : 1;
  localparam int unsigned DIV1 = (CLK_FREQ_HZ / SPEED1_HZ > 0) ? CLK_FREQ_HZ / SPEED1_HZ : 1;
  localparam int unsigned DIV2 = (CLK_FREQ_HZ / SPEED2_HZ > 0) ? CLK_FREQ_HZ / SPEED2_HZ : 1;
  localparam int unsigned DIV3 = (CLK_FREQ_HZ / SPEED3_HZ > 0) ? CLK_FREQ_HZ / SPEED3_HZ : 1;
  localparam int CNT_W = (DIV0 > 1) ? $clog2(DIV0) : 1;  // Speed 0 is the slowest

  xcvr_state_t state;
  xcvr_state_t state_next;
  logic [8:0] buffer;
  logic [8:0] buffer_next;
  logic       sclk_next;
  logic [2:0] bits;
  logic [2:0] bits_next;

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] div_sel;
  logic             tick;

  logic [1:0] speed_sel;
  logic       cpol;
  logic       cpha;

  assign speed_sel = conf[CONF_SPEED_LSB +: 2];
  assign cpol = conf[CONF_CPOL_BIT];
  assign cpha = conf[CONF_CPHA_BIT];

  assign done = (state == XCVR_IDLE);
  assign mosi = buffer[8];
  assign rx = cpha ? buffer[7:0] : buffer[8:1];  // CPHA 0 ends on a shift, one bit higher

  always_comb begin
    case (speed_sel)
      2'd0: div_sel = CNT_W'(DIV0 - 1);
      2'd1: div_sel = CNT_W'(DIV1 - 1);
      2'd2: div_sel = CNT_W'(DIV2 - 1);
      default: div_sel = CNT_W'(DIV3 - 1);
    endcase
  end

  assign tick = (state != XCVR_IDLE) && (cnt == div_sel);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt <= '0;
    end else if (state == XCVR_IDLE || tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= XCVR_IDLE;
      buffer <= '0;
      sclk <= 1'b0;
      bits <= '0;
    end else begin
      state <= state_next;
      buffer <= buffer_next;
      sclk <= sclk_next;
      bits <= bits_next;
    end
  end

  always_comb begin
    state_next = state;
    buffer_next = buffer;
    sclk_next = sclk;
    bits_next = bits;
    case (state)
      XCVR_IDLE: begin
        sclk_next = cpol;  // Park at idle level
        if (start) begin
          buffer_next = cpha ? {1'b0, tx} : {tx, 1'b0};
          bits_next = 3'(XFER_BITS - 1);
          state_next = XCVR_START;
        end
      end
      XCVR_START: begin
        if (tick) begin
          state_next = XCVR_LEAD;
        end
      end
      XCVR_LEAD: begin
        if (tick) begin
          if (cpha) begin
            buffer_next = {buffer[7:0], 1'b0};  // Shift out on leading edge
          end else begin
            buffer_next[0] = miso;
          end
          sclk_next = ~sclk;
          state_next = XCVR_TRAIL;
        end
      end
      XCVR_TRAIL: begin
        if (tick) begin
          if (cpha) begin
            buffer_next[0] = miso;  // Sample on trailing edge
          end else begin
            buffer_next = {buffer[7:0], 1'b0};
          end
          sclk_next = ~sclk;
          bits_next = bits - 1'b1;
          state_next = (bits == '0) ? XCVR_IDLE : XCVR_LEAD;
        end
      end
      default: state_next = XCVR_IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== spi_req_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_req_queue #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_valid,
  input  spi_pkg::spi_byte_t req_data,
  output logic              credit,
  output logic              q_valid,
  output spi_pkg::spi_byte_t q_data,
  input  logic              q_pop
);

  import spi_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  spi_byte_t mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count == CNT_W'(QUEUE_DEPTH));
  assign push = req_valid && !full;  // Dropped only if the host ignores credits
  assign pop = q_pop && q_valid;

  assign q_valid = (count != '0);
  assign q_data = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= req_data;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop;  // One credit back per entry handed on
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== spi_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_arbiter (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              q_valid_a,
  input  logic              q_valid_b,
  input  spi_pkg::spi_byte_t q_data_a,
  input  spi_pkg::spi_byte_t q_data_b,
  output logic              q_pop_a,
  output logic              q_pop_b,
  input  spi_pkg::spi_conf_t conf_a,
  input  spi_pkg::spi_conf_t conf_b,
  output logic              rsp_valid_a,
  output logic              rsp_valid_b,
  output spi_pkg::spi_byte_t rsp_data_a,
  output spi_pkg::spi_byte_t rsp_data_b,
  output logic              cs_n_a,
  output logic              cs_n_b,
  output logic              start,
  output spi_pkg::spi_byte_t tx,
  output spi_pkg::spi_conf_t conf,
  input  spi_pkg::spi_byte_t rx,
  input  logic              done
);

  import spi_pkg::*;

  typedef enum logic [1:0] {
    ARB_FREE,
    ARB_LAUNCH,
    ARB_WAIT
  } arb_state_t;

  arb_state_t state;
  logic       last_b;  // Also the owner while a byte is in flight
  logic       pick_b;
  logic       grant;
  spi_conf_t  pick_conf;
  spi_byte_t  tx_q;
  spi_conf_t  conf_q;
  spi_byte_t  rsp_q;

  // Prefer the channel that was not served last
  assign pick_b = q_valid_b && (!q_valid_a || !last_b);
  assign pick_conf = pick_b ? conf_b : conf_a;
  assign grant = (state == ARB_FREE) && (q_valid_a || q_valid_b);

  assign q_pop_a = grant && !pick_b;
  assign q_pop_b = grant && pick_b;

  assign start = (state == ARB_LAUNCH);
  assign tx = tx_q;
  // While free, show the candidate's mode so SCLK parks at its CPOL before CS falls
  assign conf = (state == ARB_FREE) ? pick_conf : conf_q;

  assign rsp_data_a = rsp_q;
  assign rsp_data_b = rsp_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= ARB_FREE;
      last_b <= 1'b1;  // Channel a goes first
      cs_n_a <= 1'b1;
      cs_n_b <= 1'b1;
      rsp_valid_a <= 1'b0;
      rsp_valid_b <= 1'b0;
    end else begin
      rsp_valid_a <= 1'b0;
      rsp_valid_b <= 1'b0;
      case (state)
        ARB_FREE: begin
          if (grant) begin
            state <= ARB_LAUNCH;
            last_b <= pick_b;
            cs_n_a <= pick_b;
            cs_n_b <= !pick_b;
          end
        end
        ARB_LAUNCH: begin
          if (done) begin
            state <= ARB_WAIT;  // Start taken this cycle
          end
        end
        ARB_WAIT: begin
          if (done) begin
            state <= ARB_FREE;
            cs_n_a <= 1'b1;
            cs_n_b <= 1'b1;
            rsp_valid_a <= !last_b;
            rsp_valid_b <= last_b;
          end
        end
        default: state <= ARB_FREE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      tx_q <= pick_b ? q_data_b : q_data_a;
      conf_q <= pick_conf;
    end
    if (state == ARB_WAIT && done) begin
      rsp_q <= rx;
    end
  end

endmodule

`default_nettype wire

// ==== spi_subsys_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_subsys_top #(
  parameter int unsigned CLK_FREQ_HZ = 100_000_000,
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_valid_a,
  input  spi_pkg::spi_byte_t req_data_a,
  output logic              credit_a,
  input  spi_pkg::spi_conf_t conf_a,
  output logic              rsp_valid_a,
  output spi_pkg::spi_byte_t rsp_data_a,
  output logic              cs_n_a,
  input  logic              req_valid_b,
  input  spi_pkg::spi_byte_t req_data_b,
  output logic              credit_b,
  input  spi_pkg::spi_conf_t conf_b,
  output logic              rsp_valid_b,
  output spi_pkg::spi_byte_t rsp_data_b,
  output logic              cs_n_b,
  output logic              sclk,
  output logic              mosi,
  input  logic              miso
);

  import spi_pkg::*;

  logic      q_valid_a;
  logic      q_valid_b;
  spi_byte_t q_data_a;
  spi_byte_t q_data_b;
  logic      q_pop_a;
  logic      q_pop_b;

  logic      start;
  logic      done;
  spi_byte_t tx;
  spi_byte_t rx;
  spi_conf_t xcvr_conf;

  spi_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) spi_req_queue_a_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .req_valid(req_valid_a), .req_data(req_data_a), .credit(credit_a),
    .q_valid(q_valid_a), .q_data(q_data_a), .q_pop(q_pop_a)
  );

  spi_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) spi_req_queue_b_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .req_valid(req_valid_b), .req_data(req_data_b), .credit(credit_b),
    .q_valid(q_valid_b), .q_data(q_data_b), .q_pop(q_pop_b)
  );

  spi_arbiter spi_arbiter_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .q_valid_a(q_valid_a), .q_valid_b(q_valid_b),
    .q_data_a(q_data_a), .q_data_b(q_data_b),
    .q_pop_a(q_pop_a), .q_pop_b(q_pop_b),
    .conf_a(conf_a), .conf_b(conf_b),
    .rsp_valid_a(rsp_valid_a), .rsp_valid_b(rsp_valid_b),
    .rsp_data_a(rsp_data_a), .rsp_data_b(rsp_data_b),
    .cs_n_a(cs_n_a), .cs_n_b(cs_n_b),
    .start(start), .tx(tx), .conf(xcvr_conf), .rx(rx), .done(done)
  );

  spi_xcvr #(.CLK_FREQ_HZ(CLK_FREQ_HZ)) spi_xcvr_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .conf(xcvr_conf), .start(start), .tx(tx), .rx(rx), .done(done),
    .miso(miso), .mosi(mosi), .sclk(sclk)
  );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD_NS = 5,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);  // Release away from the rising edge
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_spi_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_spi_slave (
  input  logic       cs_n,
  input  logic       sclk,
  input  logic       mosi,
  input  logic [1:0] mode,
  output logic       miso,
  output logic [7:0] pulses
);

  logic [7:0] reply;
  logic [7:0] tx_sr;
  logic [7:0] rx_sr;
  logic       miso_q;

  assign miso = !cs_n && miso_q;  // Zero while deselected

  initial begin
    reply = 8'hA5;  // First reply after reset
    tx_sr = '0;
    rx_sr = '0;
    miso_q = 1'b0;
    pulses = '0;
    forever begin
      @(negedge cs_n);
      tx_sr = reply;
      rx_sr = '0;
      pulses = '0;
      miso_q = mode[0] ? 1'b0 : reply[7];  // CPHA 0 needs bit 7 before the first edge
      while (!cs_n) begin
        @(sclk or cs_n);
        if (!cs_n) begin
          if (sclk != mode[1]) begin  // Leading edge
            pulses = pulses + 8'd1;
            if (mode[0]) begin
              miso_q = tx_sr[7];
              tx_sr = {tx_sr[6:0], 1'b0};
            end else begin
              rx_sr = {rx_sr[6:0], mosi};
            end
          end else if (mode[0]) begin
            rx_sr = {rx_sr[6:0], mosi};
          end else begin
            tx_sr = {tx_sr[6:0], 1'b0};
            miso_q = tx_sr[7];
          end
        end
      end
      reply = rx_sr;  // Echoed on the next transfer
    end
  end

endmodule

`default_nettype wire

// ==== tb_spi_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_spi_subsys;

  import spi_pkg::*;

  localparam int unsigned CLK_FREQ_HZ = 100_000_000;
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned NUM_TESTS = 5;
  localparam int unsigned BYTE_CYCLES = 17 * (CLK_FREQ_HZ / SPEED0_HZ) + 8;  // Slowest speed
  localparam int unsigned WATCHDOG_NS = (NUM_TESTS * 8 * BYTE_CYCLES + 2000) * 10;

  logic      clk_i;
  logic      rst_i;
  logic      req_valid_a;
  logic      req_valid_b;
  spi_byte_t req_data_a;
  spi_byte_t req_data_b;
  spi_conf_t conf_a;
  spi_conf_t conf_b;
  logic      credit_a;
  logic      credit_b;
  logic      rsp_valid_a;
  logic      rsp_valid_b;
  spi_byte_t rsp_data_a;
  spi_byte_t rsp_data_b;
  logic      cs_n_a;
  logic      cs_n_b;
  logic      sclk;
  logic      mosi;
  logic      miso;
  logic      miso_a;
  logic      miso_b;
  logic [7:0] pulses_a;
  logic [7:0] pulses_b;

  int        seed;
  int        pushes [2];
  int        credit_pulses [2];
  int        rsp_count [2];
  int        cs_falls [2];
  int        last_owner;
  int        order_base;
  spi_byte_t last_sent [2];
  spi_byte_t exp_rsp [2][64];  // Scoreboard in request order
  logic      idle_check;
  logic      idle_cpol;
  logic      order_check;
  logic      cs_n_a_prev;
  logic      cs_n_b_prev;

  tb_clk_gen #(.HALF_PERIOD_NS(5), .RESET_CYCLES(3)) tb_clk_gen_i (.clk(clk_i), .rst(rst_i));

  spi_subsys_top #(.CLK_FREQ_HZ(CLK_FREQ_HZ), .QUEUE_DEPTH(QUEUE_DEPTH)) spi_subsys_top_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .req_valid_a(req_valid_a), .req_data_a(req_data_a), .credit_a(credit_a),
    .conf_a(conf_a), .rsp_valid_a(rsp_valid_a), .rsp_data_a(rsp_data_a), .cs_n_a(cs_n_a),
    .req_valid_b(req_valid_b), .req_data_b(req_data_b), .credit_b(credit_b),
    .conf_b(conf_b), .rsp_valid_b(rsp_valid_b), .rsp_data_b(rsp_data_b), .cs_n_b(cs_n_b),
    .sclk(sclk), .mosi(mosi), .miso(miso)
  );

  tb_spi_slave slave_a_i (.cs_n(cs_n_a), .sclk(sclk), .mosi(mosi), .mode(conf_a[1:0]),
    .miso(miso_a), .pulses(pulses_a));
  tb_spi_slave slave_b_i (.cs_n(cs_n_b), .sclk(sclk), .mosi(mosi), .mode(conf_b[1:0]),
    .miso(miso_b), .pulses(pulses_b));

  assign miso = miso_a | miso_b;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at %0d ns: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Run stopped on first error");
    end
  endtask

  task automatic fail_run(input string reason);
    $display("Error at %0d ns: %s", $time, reason);
    $display("Some tests failed");
    $fatal(1, "Run stopped on first error");
  endtask

  function automatic int credits_left(input int ch);
    return int'(QUEUE_DEPTH) - pushes[ch] + credit_pulses[ch];
  endfunction

  task automatic record_cs_fall(input int owner);
    if (order_check && (cs_falls[0] + cs_falls[1] > order_base)) begin
      check_value("cs_fall_owner", 32'(1 - last_owner), 32'(owner));  // Must alternate
    end
    cs_falls[owner]++;
    last_owner = owner;
  endtask

  task automatic check_response(input int ch, input spi_byte_t data, input logic [7:0] pulses);
    if (rsp_count[ch] >= pushes[ch]) begin
      fail_run("response arrived with no request pending");
    end
    check_value(ch == 0 ? "rsp_data_a" : "rsp_data_b", 32'(exp_rsp[ch][rsp_count[ch]]),
                32'(data));
    check_value("sclk_pulses", 32'd8, 32'(pulses));
    rsp_count[ch]++;
  endtask

  always @(negedge clk_i) begin
    if (rst_i) begin
      credit_pulses = '{0, 0};
      rsp_count = '{0, 0};
      cs_falls = '{0, 0};
      last_owner = 1;
    end else begin
      if (credit_a) credit_pulses[0]++;
      if (credit_b) credit_pulses[1]++;
      if (!cs_n_a && !cs_n_b) fail_run("both chip selects are low at once");
      if (cs_n_a_prev && !cs_n_a) record_cs_fall(0);
      if (cs_n_b_prev && !cs_n_b) record_cs_fall(1);
      if (rsp_valid_a) check_response(0, rsp_data_a, pulses_a);
      if (rsp_valid_b) check_response(1, rsp_data_b, pulses_b);
      if (idle_check && cs_n_a && cs_n_b) check_value("sclk", 32'(idle_cpol), 32'(sclk));
    end
    cs_n_a_prev = cs_n_a;
    cs_n_b_prev = cs_n_b;
  end

  task automatic send_byte(input int ch, input spi_byte_t data);
    while (credits_left(ch) <= 0) @(negedge clk_i);  // Host holds off without credit
    exp_rsp[ch][pushes[ch]] = last_sent[ch];
    last_sent[ch] = data;
    pushes[ch]++;
    if (ch == 0) begin
      req_valid_a = 1'b1;
      req_data_a = data;
    end else begin
      req_valid_b = 1'b1;
      req_data_b = data;
    end
    @(negedge clk_i);
    if (ch == 0) req_valid_a = 1'b0;
    else req_valid_b = 1'b0;
  endtask

  task automatic send_burst(input int ch, input int count);
    for (int i = 0; i < count; i++) send_byte(ch, 8'($random(seed)));
  endtask

  task automatic wait_responses();
    while (rsp_count[0] != pushes[0] || rsp_count[1] != pushes[1]) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
  endtask

  task automatic set_conf(input spi_conf_t conf);
    conf_a = conf;
    conf_b = conf;
    repeat (3) @(negedge clk_i);  // Let SCLK park at the new CPOL
  endtask

  task automatic test_reset_state();
    check_value("cs_n_a", 32'd1, 32'(cs_n_a));
    check_value("cs_n_b", 32'd1, 32'(cs_n_b));
    check_value("rsp_valid_a", 32'd0, 32'(rsp_valid_a));
    check_value("rsp_valid_b", 32'd0, 32'(rsp_valid_b));
    check_value("credit_a", 32'd0, 32'(credit_a));
    check_value("credit_b", 32'd0, 32'(credit_b));
    check_value("sclk", 32'd0, 32'(sclk));
  endtask

  task automatic test_single_bytes();
    int falls_a;
    int falls_b;
    set_conf(4'b1000);
    for (int i = 0; i < 2; i++) begin
      for (int ch = 0; ch < 2; ch++) begin
        falls_a = cs_falls[0];
        falls_b = cs_falls[1];
        send_byte(ch, 8'($random(seed)));
        wait_responses();
        check_value("cs_falls_a", 32'(falls_a + (ch == 0 ? 1 : 0)), 32'(cs_falls[0]));
        check_value("cs_falls_b", 32'(falls_b + (ch == 1 ? 1 : 0)), 32'(cs_falls[1]));
      end
    end
  endtask

  task automatic test_modes();
    for (int mode = 0; mode < 4; mode++) begin
      for (int s = 0; s < 2; s++) begin
        idle_check = 1'b0;
        set_conf({2'((mode + s) % 4), 2'(mode)});  // Speeds rotate through all four
        idle_cpol = conf_a[CONF_CPOL_BIT];
        idle_check = 1'b1;
        check_value("sclk", 32'(idle_cpol), 32'(sclk));
        send_byte(0, 8'($random(seed)));
        send_byte(1, 8'($random(seed)));
        wait_responses();
      end
    end
    idle_check = 1'b0;
  endtask

  task automatic test_both_busy();
    set_conf(4'b1100);
    order_base = cs_falls[0] + cs_falls[1];
    order_check = 1'b1;
    fork
      send_burst(0, 8);
      send_burst(1, 8);
    join
    wait_responses();
    order_check = 1'b0;
  endtask

  task automatic test_credits();
    int base_credit;
    set_conf(4'b0100);
    for (int round = 0; round < 2; round++) begin  // Second round refills from returned credit
      base_credit = credit_pulses[0];
      send_burst(0, int'(QUEUE_DEPTH));
      wait_responses();
      repeat (4) @(negedge clk_i);
      check_value("credit_pulses_a", QUEUE_DEPTH, 32'(credit_pulses[0] - base_credit));
      check_value("credits_left_a", QUEUE_DEPTH, 32'(credits_left(0)));
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Some tests failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    seed = 32'hdea88fc4;
    req_valid_a = 1'b0;
    req_valid_b = 1'b0;
    req_data_a = '0;
    req_data_b = '0;
    conf_a = '0;
    conf_b = '0;
    idle_check = 1'b0;
    idle_cpol = 1'b0;
    order_check = 1'b0;
    order_base = 0;
    pushes = '{0, 0};
    last_sent = '{8'hA5, 8'hA5};  // Each slave's first reply
    @(negedge rst_i);
    @(negedge clk_i);
    test_reset_state();
    test_single_bytes();
    test_modes();
    test_both_busy();
    test_credits();
    repeat (5) @(negedge clk_i);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== spi_subsys_top.f ====
spi_pkg.sv
spi_xcvr.sv
spi_req_queue.sv
spi_arbiter.sv
spi_subsys_top.sv
tb_clk_gen.sv
tb_spi_slave.sv
tb_spi_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_spi_subsys \
  -f spi_subsys_top.f -Mdir obj_dir -o tb_spi_subsys
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/tb_spi_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
